// ==== uart_pkg.sv ====
package uart_pkg;

	// parity sense of the optional parity bit
	typedef enum logic {
		PARITY_EVEN = 1'b0, // data xor parity is 0
		PARITY_ODD  = 1'b1  // data xor parity is 1
	} parity_e;

	// receiver phases, one per field of the frame
	typedef enum logic [2:0] {
		RX_IDLE   = 3'd0, // line high, waiting for falling edge
		RX_START  = 3'd1, // counting to start bit centre
		RX_DATA   = 3'd2, // sampling data bits
		RX_PARITY = 3'd3, // sampling parity bit
		RX_STOP   = 3'd4  // sampling stop bit, word is presented here
	} rx_state_e;

	// ticks per serial bit
	// rx centre sampling counts half of this to reach mid start bit
	localparam int OVERSAMPLE = 8;

	// flops in the rx input synchronizer
	localparam int SYNC_STAGES = 3;

endpackage

// ==== uart_baud_gen.sv ====
module uart_baud_gen #(
	parameter int CLKS_PER_TICK = 16 // clk cycles per oversampling tick
) (
	input  logic clk,
	input  logic reset,
	output logic o_tick
);

	// counter needs at least one bit even for a divide by one
	localparam int CNT_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;

	logic [CNT_W-1:0] clk_cnt; // cycles since last tick

	always_ff @(posedge clk) begin
		if (reset) begin
			clk_cnt <= '0;
			o_tick  <= 1'b0;
		end else if (clk_cnt == CNT_W'(CLKS_PER_TICK - 1)) begin
			clk_cnt <= '0;   // wrap
			o_tick  <= 1'b1; // one cycle strobe
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
			o_tick  <= 1'b0;
		end
	end

endmodule

// ==== uart_tx.sv ====
module uart_tx import uart_pkg::*; #(
	parameter int      DATA_WIDTH     = 8,          // data bits per frame
	parameter int      PARITY_ENABLED = 1,          // 1 sends a parity bit
	parameter parity_e PARITY_TYPE    = PARITY_EVEN // even or odd sense
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_tick,   // oversampling strobe
	input  logic                  i_enable, // single cycle send request
	input  logic [DATA_WIDTH-1:0] i_data,   // word, taken with i_enable
	output logic                  o_busy,   // high for the whole frame
	output logic                  o_tx      // serial line, idles high
);

	// start + data + optional parity + stop
	localparam int FRAME_W = DATA_WIDTH + PARITY_ENABLED + 2;
	localparam int TICK_W  = $clog2(OVERSAMPLE);
	localparam int BIT_W   = $clog2(FRAME_W);

	logic [FRAME_W-1:0] shift_reg;  // PISO, bit 0 goes out next
	logic [FRAME_W-1:0] frame_load; // frame built from i_data
	logic [TICK_W-1:0]  tick_cnt;   // ticks into current bit
	logic [BIT_W-1:0]   bit_cnt;    // index of bit on the line
	logic               started;    // start bit is on the line
	logic               parity_bit;
	logic               accept;     // enable taken this cycle

	assign accept = i_enable && !o_busy; // enable while busy is dropped

	// even parity is the plain xor, odd flips it
	assign parity_bit = (^i_data) ^ (PARITY_TYPE == PARITY_ODD);

	always_comb begin
		frame_load                 = '1;
		frame_load[0]              = 1'b0;   // start bit
		frame_load[DATA_WIDTH:1]   = i_data; // lsb first on the line
		if (PARITY_ENABLED != 0) begin
			frame_load[DATA_WIDTH+1] = parity_bit;
		end
		frame_load[FRAME_W-1]      = 1'b1;   // stop bit
	end

	// frame register shifts right once per bit period
	always_ff @(posedge clk) begin
		if (accept) begin
			shift_reg <= frame_load;
		end else if (o_busy && i_tick) begin
			if (!started || tick_cnt == TICK_W'(OVERSAMPLE - 1)) begin
				shift_reg <= {1'b1, shift_reg[FRAME_W-1:1]}; // next bit to bit 0
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			o_busy   <= 1'b0;
			o_tx     <= 1'b1; // idle line
			started  <= 1'b0;
			tick_cnt <= '0;
			bit_cnt  <= '0;
		end else if (accept) begin
			o_busy  <= 1'b1;
			started <= 1'b0; // wait for the next tick to align the start bit
		end else if (o_busy && i_tick) begin
			if (!started) begin
				o_tx     <= shift_reg[0]; // start bit
				started  <= 1'b1;
				tick_cnt <= '0;
				bit_cnt  <= '0;
			end else if (tick_cnt == TICK_W'(OVERSAMPLE - 1)) begin
				tick_cnt <= '0;
				if (bit_cnt == BIT_W'(FRAME_W - 1)) begin
					// stop bit done, line stays high
					o_busy  <= 1'b0;
					started <= 1'b0;
					o_tx    <= 1'b1;
				end else begin
					o_tx    <= shift_reg[0];
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== uart_rx.sv ====
module uart_rx import uart_pkg::*; #(
	parameter int      DATA_WIDTH     = 8,          // data bits per frame
	parameter int      PARITY_ENABLED = 1,          // 1 expects a parity bit
	parameter parity_e PARITY_TYPE    = PARITY_EVEN // even or odd sense
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_tick,       // oversampling strobe
	input  logic                  i_rx,         // asynchronous serial line
	output logic [DATA_WIDTH-1:0] o_data,       // last received word
	output logic                  o_data_valid, // one cycle at stop sample
	output logic                  o_rx_error    // parity mismatch, with valid
);

	localparam int TICK_W = $clog2(OVERSAMPLE);
	localparam int BIT_W  = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;

	// start bit centre is half a bit after the edge
	localparam logic [TICK_W-1:0] HALF_BIT = TICK_W'(OVERSAMPLE / 2 - 1);
	localparam logic [TICK_W-1:0] FULL_BIT = TICK_W'(OVERSAMPLE - 1);

	// accumulator seed, so a good frame always ends at zero
	localparam logic PARITY_SEED = (PARITY_TYPE == PARITY_ODD);

	logic [SYNC_STAGES-1:0] sync_q;     // metastability chain
	logic                   rx_bit;     // synchronized line
	rx_state_e              state;
	logic [TICK_W-1:0]      tick_cnt;   // ticks since last sample
	logic [BIT_W-1:0]       bit_cnt;    // data bits taken so far
	logic [DATA_WIDTH-1:0]  shift_reg;  // word being assembled
	logic                   parity_acc; // running xor of data and parity
	logic                   sample;     // bit centre reached this cycle

	assign rx_bit = sync_q[SYNC_STAGES-1];
	assign sample = i_tick && (tick_cnt == FULL_BIT);

	// resets to one so an idle line does not look like a start edge
	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q <= '1;
		end else begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], i_rx};
		end
	end

	// data shifts in at the top, so the first bit ends up at bit 0
	always_ff @(posedge clk) begin
		if (state == RX_DATA && sample) begin
			shift_reg <= {rx_bit, shift_reg[DATA_WIDTH-1:1]};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= RX_IDLE;
			tick_cnt     <= '0;
			bit_cnt      <= '0;
			parity_acc   <= 1'b0;
			o_data       <= '0;
			o_data_valid <= 1'b0;
			o_rx_error   <= 1'b0;
		end else begin
			o_data_valid <= 1'b0; // pulses by default
			o_rx_error   <= 1'b0;

			// tick counter runs in every state but idle
			if (state == RX_IDLE) begin
				tick_cnt <= '0;
			end else if (i_tick) begin
				if (tick_cnt == FULL_BIT || (state == RX_START && tick_cnt == HALF_BIT)) begin
					tick_cnt <= '0;
				end else begin
					tick_cnt <= tick_cnt + 1'b1;
				end
			end

			case (state)
				RX_IDLE: begin
					if (!rx_bit) begin
						state <= RX_START; // falling edge seen
					end
				end
				RX_START: begin
					if (i_tick && tick_cnt == HALF_BIT) begin
						if (!rx_bit) begin
							state      <= RX_DATA; // confirmed at mid start bit
							bit_cnt    <= '0;
							parity_acc <= PARITY_SEED;
						end else begin
							state <= RX_IDLE; // glitch, back to waiting
						end
					end
				end
				RX_DATA: begin
					if (sample) begin
						parity_acc <= parity_acc ^ rx_bit;
						if (bit_cnt == BIT_W'(DATA_WIDTH - 1)) begin
							state <= (PARITY_ENABLED != 0) ? RX_PARITY : RX_STOP;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				RX_PARITY: begin
					if (sample) begin
						parity_acc <= parity_acc ^ rx_bit;
						state      <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (sample) begin
						o_data       <= shift_reg; // held until the next frame
						o_data_valid <= 1'b1;
						o_rx_error   <= (PARITY_ENABLED != 0) && parity_acc;
						state        <= RX_IDLE;   // mid stop bit, line is high
					end
				end
				default: begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== uart_top.sv ====
module uart_top import uart_pkg::*; #(
	parameter int      DATA_WIDTH     = 8,           // 5 to 9 data bits
	parameter int      PARITY_ENABLED = 1,           // 0 drops the parity bit
	parameter parity_e PARITY_TYPE    = PARITY_EVEN,
	parameter int      CLKS_PER_TICK  = 16           // baud divisor
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_enable,     // tx send strobe
	input  logic [DATA_WIDTH-1:0] i_data,       // tx word
	output logic                  o_busy,       // tx frame in progress
	output logic                  o_tx,         // tx serial line
	input  logic                  i_rx,         // rx serial line
	output logic [DATA_WIDTH-1:0] o_data,       // rx word
	output logic                  o_data_valid, // rx word strobe
	output logic                  o_rx_error    // rx parity error strobe
);

	logic tick; // shared so tx and rx agree on the bit period

	uart_baud_gen #(
		.CLKS_PER_TICK(CLKS_PER_TICK)
	) u_baud_gen (
		.clk   (clk),
		.reset (reset),
		.o_tick(tick)
	);

	uart_tx #(
		.DATA_WIDTH    (DATA_WIDTH),
		.PARITY_ENABLED(PARITY_ENABLED),
		.PARITY_TYPE   (PARITY_TYPE)
	) u_tx (
		.clk     (clk),
		.reset   (reset),
		.i_tick  (tick),
		.i_enable(i_enable),
		.i_data  (i_data),
		.o_busy  (o_busy),
		.o_tx    (o_tx)
	);

	uart_rx #(
		.DATA_WIDTH    (DATA_WIDTH),
		.PARITY_ENABLED(PARITY_ENABLED),
		.PARITY_TYPE   (PARITY_TYPE)
	) u_rx (
		.clk         (clk),
		.reset       (reset),
		.i_tick      (tick),
		.i_rx        (i_rx),
		.o_data      (o_data),
		.o_data_valid(o_data_valid),
		.o_rx_error  (o_rx_error)
	);

endmodule

// ==== tb_uart.sv ====
module tb_uart import uart_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DATA_WIDTH    = 8;
	localparam int CLKS_PER_TICK = 4;
	localparam int BIT_CLKS      = OVERSAMPLE * CLKS_PER_TICK; // clk cycles per serial bit
	localparam int FRAME_BITS    = DATA_WIDTH + 3;             // start, data, parity, stop
	localparam int FRAME_CLKS    = FRAME_BITS * BIT_CLKS;

	logic                  clk;
	logic                  reset;
	logic                  i_enable;
	logic [DATA_WIDTH-1:0] i_data;
	logic                  o_busy;
	logic                  o_tx;
	logic                  rx_line;
	logic [DATA_WIDTH-1:0] o_data;
	logic                  o_data_valid;
	logic                  o_rx_error;

	logic                  loop_mode;   // 1 ties o_tx back to i_rx
	logic                  bang_line;   // serial line from the bit-banger
	logic [31:0]           lfsr;        // random state
	logic [DATA_WIDTH-1:0] exp_words[$]; // reference model queue
	logic                  exp_errs[$];  // expected parity error per word
	logic [DATA_WIDTH-1:0] last_word;   // model word o_data holds between frames
	logic                  monitor_on;
	logic                  busy_prev;
	int                    valid_count;
	int                    busy_falls;
	int                    value_errors;
	int                    other_errors;

	assign rx_line = loop_mode ? o_tx : bang_line; // serial line mux

	uart_top #(
		.DATA_WIDTH    (DATA_WIDTH),
		.PARITY_ENABLED(1),
		.PARITY_TYPE   (PARITY_EVEN),
		.CLKS_PER_TICK (CLKS_PER_TICK)
	) DUT (
		.clk         (clk),
		.reset       (reset),
		.i_enable    (i_enable),
		.i_data      (i_data),
		.o_busy      (o_busy),
		.o_tx        (o_tx),
		.i_rx        (rx_line),
		.o_data      (o_data),
		.o_data_valid(o_data_valid),
		.o_rx_error  (o_rx_error)
	);

	always #10 clk = ~clk; // 20 ns period

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit taken
	task automatic draw_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
	endtask

	function automatic logic even_parity(input logic [DATA_WIDTH-1:0] w);
		even_parity = ^w; // makes data plus parity an even count of ones
	endfunction

	// bit 0 goes on the line first
	function automatic logic [FRAME_BITS-1:0] frame_bits(input logic [DATA_WIDTH-1:0] w,
		input logic par);
		frame_bits = {1'b1, par, w, 1'b0};
	endfunction

	task automatic wait_busy(input logic level, input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (o_busy !== level && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (o_busy !== level) begin
			$display("timeout: o_busy did not reach %0d within %0d cycles", level, limit);
			other_errors++;
		end
	endtask

	task automatic wait_valid_count(input int target, input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (valid_count < target && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (valid_count < target) begin
			$display("timeout: no received word after %0d cycles", limit);
			other_errors++;
		end
	endtask

	// loopback send, the word goes into the model queue
	task automatic send_word(input logic [DATA_WIDTH-1:0] w);
		wait_busy(1'b0, FRAME_CLKS + BIT_CLKS);
		exp_words.push_back(w);
		exp_errs.push_back(1'b0);
		@(posedge clk);
		i_enable <= 1'b1;
		i_data   <= w;
		@(posedge clk);
		i_enable <= 1'b0;
		@(negedge clk);
		if (o_busy !== 1'b1) begin // rises one cycle after acceptance
			$display("CHECK FAILED o_busy expected %h got %h", 1'b1, o_busy);
			value_errors++;
		end
	endtask

	// samples o_tx at every bit centre, starting from the start edge
	task automatic check_frame(input logic [DATA_WIDTH-1:0] w);
		logic [FRAME_BITS-1:0] bits;
		int                    n;
		bits = frame_bits(w, even_parity(w));
		n    = 0;
		@(negedge clk);
		while (o_tx !== 1'b0 && n < 2 * CLKS_PER_TICK) begin
			@(negedge clk);
			n++;
		end
		if (o_tx !== 1'b0) begin
			$display("timeout: no start bit on o_tx after o_busy rose");
			other_errors++;
		end else begin
			repeat (BIT_CLKS / 2) @(negedge clk);
			for (int i = 0; i < FRAME_BITS; i++) begin
				if (o_tx !== bits[i]) begin
					$display("CHECK FAILED o_tx bit %0d expected %h got %h", i, bits[i], o_tx);
					value_errors++;
				end
				if (i < FRAME_BITS - 1) begin
					repeat (BIT_CLKS) @(negedge clk);
				end
			end
		end
	endtask

	// drives one frame on the testbench line, parity bit as given
	task automatic bang_frame(input logic [DATA_WIDTH-1:0] w, input logic par);
		logic [FRAME_BITS-1:0] bits;
		bits = frame_bits(w, par);
		@(posedge clk);
		for (int i = 0; i < FRAME_BITS; i++) begin
			bang_line <= bits[i];
			repeat (BIT_CLKS) @(posedge clk);
		end
		bang_line <= 1'b1;
	endtask

	// receive side checker, compares every valid with the model
	always @(negedge clk) begin : rx_monitor
		logic [DATA_WIDTH-1:0] exp_w;
		logic                  exp_e;
		if (monitor_on) begin
			if (busy_prev && !o_busy) begin
				busy_falls++;
			end
			busy_prev = o_busy;
			if (o_data_valid === 1'b1) begin
				valid_count++;
				if (exp_words.size() == 0) begin
					$display("o_data_valid pulsed while no word was expected");
					other_errors++;
				end else begin
					exp_w = exp_words.pop_front();
					exp_e = exp_errs.pop_front();
					if (o_data !== exp_w) begin
						$display("CHECK FAILED o_data expected %h got %h", exp_w, o_data);
						value_errors++;
					end
					if (o_rx_error !== exp_e) begin
						$display("CHECK FAILED o_rx_error expected %h got %h", exp_e, o_rx_error);
						value_errors++;
					end
					last_word = exp_w; // must stay on o_data until the next valid
				end
			end else begin
				if (o_rx_error !== 1'b0) begin // only allowed with valid
					$display("CHECK FAILED o_rx_error expected %h got %h", 1'b0, o_rx_error);
					value_errors++;
				end
				if (o_data !== last_word) begin // held between frames
					$display("CHECK FAILED o_data expected %h got %h", last_word, o_data);
					value_errors++;
				end
			end
		end
	end

	initial begin
		logic [31:0]           r;
		logic [DATA_WIDTH-1:0] w;
		logic                  flip;
		int                    target;
		int                    falls_before;

		clk          = 1'b0;
		reset        = 1'b1;
		i_enable     = 1'b0;
		i_data       = '0;
		loop_mode    = 1'b1;
		bang_line    = 1'b1;
		lfsr         = 32'h5a3c;
		last_word    = '0;
		monitor_on   = 1'b0;
		busy_prev    = 1'b0;
		valid_count  = 0;
		busy_falls   = 0;
		value_errors = 0;
		other_errors = 0;

		repeat (3) @(posedge clk);
		reset <= 1'b0;

		// reset values, then an idle stretch under the monitor
		@(negedge clk);
		if (o_tx !== 1'b1) begin
			$display("CHECK FAILED o_tx expected %h got %h", 1'b1, o_tx);
			value_errors++;
		end
		if (o_busy !== 1'b0) begin
			$display("CHECK FAILED o_busy expected %h got %h", 1'b0, o_busy);
			value_errors++;
		end
		if (o_data_valid !== 1'b0) begin
			$display("CHECK FAILED o_data_valid expected %h got %h", 1'b0, o_data_valid);
			value_errors++;
		end
		monitor_on = 1'b1; // also checks o_data is zero and error stays low
		repeat (4 * BIT_CLKS) @(negedge clk);

		// loopback words, each frame also checked on o_tx
		for (int k = 0; k < 20; k++) begin
			draw_bits(DATA_WIDTH, r);
			w      = r[DATA_WIDTH-1:0];
			target = valid_count + 1;
			send_word(w);
			check_frame(w);
			wait_valid_count(target, 2 * BIT_CLKS + SYNC_STAGES);
		end

		// second enable in the middle of a frame must be dropped
		draw_bits(DATA_WIDTH, r);
		w      = r[DATA_WIDTH-1:0];
		target = valid_count + 1;
		send_word(w);
		falls_before = busy_falls;
		repeat (5 * BIT_CLKS) @(posedge clk);
		i_enable <= 1'b1;
		i_data   <= w ^ 8'ha5;
		@(posedge clk);
		i_enable <= 1'b0;
		wait_busy(1'b0, FRAME_CLKS);
		wait_valid_count(target, 2 * BIT_CLKS + SYNC_STAGES);
		repeat (FRAME_CLKS + BIT_CLKS) @(negedge clk); // room for a wrong second frame
		if (valid_count != target) begin
			$display("CHECK FAILED valid_count expected %h got %h", target, valid_count);
			value_errors++;
		end
		if (busy_falls != falls_before + 1) begin
			$display("CHECK FAILED busy_falls expected %h got %h", falls_before + 1, busy_falls);
			value_errors++;
		end

		// bit-banger frames, some with a flipped parity bit
		@(posedge clk);
		loop_mode <= 1'b0;
		for (int k = 0; k < 12; k++) begin
			draw_bits(DATA_WIDTH, r);
			w = r[DATA_WIDTH-1:0];
			draw_bits(1, r);
			flip = r[0];
			if (k == 0) begin
				flip = 1'b1; // at least one bad frame
			end
			exp_words.push_back(w);
			exp_errs.push_back((even_parity(w) ^ flip) != even_parity(w));
			target = valid_count + 1;
			bang_frame(w, even_parity(w) ^ flip);
			wait_valid_count(target, 2 * BIT_CLKS + SYNC_STAGES);
			draw_bits(4, r);
			repeat (BIT_CLKS + r[3:0]) @(posedge clk); // uneven gap between frames
		end

		repeat (2 * BIT_CLKS) @(negedge clk);
		if (exp_words.size() != 0) begin
			$display("%0d expected words were never received", exp_words.size());
			other_errors++;
		end

		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
uart_pkg.sv
uart_baud_gen.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
tb_uart.sv

// ==== Bender.yml ====
package:
  name: uart_parity

# no external dependencies
dependencies: {}

sources:
  # package first, the rtl modules import it
  - uart_pkg.sv
  - uart_baud_gen.sv
  - uart_tx.sv
  - uart_rx.sv
  - uart_top.sv

  # testbench, top module tb_uart
  - target: test
    files:
      - tb_uart.sv
